// ==== src/sens_io_pkg.sv ====
// sensor port control types, register field positions and state encodings
`default_nettype none

package sens_io_pkg;

    typedef logic [7:0]  cmd_byte_t;       // one byte on cmd_ad / status_ad
    typedef logic [2:0]  cmd_addr_t;       // register offset in the block
    typedef logic [15:0] cmd_full_addr_t;  // AH:AL
    typedef logic [31:0] cmd_data_t;       // D3:D0
    typedef logic [9:0]  status_word_t;    // senspgm, hact, oe[3:0], in[3:0]

    localparam int CMD_BYTES = 6;          // AL, AH, D0..D3

    localparam cmd_addr_t SENSIO_CTRL   = 3'h0;
    localparam cmd_addr_t SENSIO_STATUS = 3'h1;

    localparam int SENS_CTRL_MRST      = 0;   // value, enable one bit above
    localparam int SENS_CTRL_GP_BASE   = 12;  // pin 0 mode at 13:12, enable 14
    localparam int SENS_CTRL_GP_STRIDE = 3;   // mode 2 bits + enable

    typedef enum logic [1:0] {
        GP_FLOAT,    // output disabled
        GP_LOW,
        GP_HIGH,
        GP_TRIGGER   // drive ext_sync
    } gp_mode_e;

    typedef enum logic [1:0] {
        ST_OFF,      // no packets
        ST_SINGLE,   // one packet per write
        ST_AUTO,     // send on change
        ST_ALWAYS    // send back to back
    } status_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,      // rq high, waiting for start
        ST_B1,       // seq + status[1:0]
        ST_B2        // status[9:2]
    } status_state_e;

endpackage

`default_nettype wire

// ==== src/sens_cmd_deser.sv ====
// command deserializer, gathers six address/data bytes and issues a matched register write
`timescale 1ns/1ps
`default_nettype none

module sens_cmd_deser #(
    parameter sens_io_pkg::cmd_full_addr_t SENSIO_ADDR      = 16'h0330, // block base
    parameter sens_io_pkg::cmd_full_addr_t SENSIO_ADDR_MASK = 16'h07f8  // compared bits
) (
    input  wire                         pclk,
    input  wire                         async_prst_with_sens_mrst,
    input  wire sens_io_pkg::cmd_byte_t cmd_ad_i,    // AL-AH-D0-D1-D2-D3
    input  wire                         cmd_stb_i,   // comes with AL
    output sens_io_pkg::cmd_addr_t      cmd_a_o,     // low address bits
    output sens_io_pkg::cmd_data_t      cmd_data_o,
    output logic                        cmd_we_o     // one cycle after D3
);

    logic [2:0]                  cnt_r;   // index of next byte, 0 when idle
    sens_io_pkg::cmd_full_addr_t addr_r;  // AH:AL
    sens_io_pkg::cmd_data_t      data_r;  // shifted in LSB byte first
    logic                        match;

    assign match      = ((addr_r ^ SENSIO_ADDR) & SENSIO_ADDR_MASK) == '0; // masked compare
    assign cmd_a_o    = addr_r[2:0];
    assign cmd_data_o = data_r;

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            cnt_r    <= 3'd0;
            cmd_we_o <= 1'b0;
        end else begin
            cmd_we_o <= 1'b0;                 // pulse by default
            if (cmd_stb_i) begin
                cnt_r <= 3'd1;                // restart even mid-command
            end else if (cnt_r != 3'd0) begin
                if (cnt_r == 3'(sens_io_pkg::CMD_BYTES - 1)) begin
                    cnt_r    <= 3'd0;         // D3 in this cycle
                    cmd_we_o <= match;        // drop foreign commands
                end else begin
                    cnt_r <= cnt_r + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (cmd_stb_i) begin
            addr_r[7:0] <= cmd_ad_i;          // AL
        end else if (cnt_r == 3'd1) begin
            addr_r[15:8] <= cmd_ad_i;         // AH
        end else if (cnt_r != 3'd0) begin
            data_r <= {cmd_ad_i, data_r[31:8]}; // D0 ends up at 7:0
        end
    end

endmodule

`default_nettype wire

// ==== src/sens_ctrl_regs.sv ====
// control register decode: sensor reset, GP pin mode strobes, status mode and line-active flag
`timescale 1ns/1ps
`default_nettype none

module sens_ctrl_regs #(
    parameter int NUM_GP = 4
) (
    input  wire                                 pclk,
    input  wire                                 async_prst_with_sens_mrst,
    input  wire sens_io_pkg::cmd_addr_t         cmd_a_i,
    input  wire sens_io_pkg::cmd_data_t         cmd_data_i,
    input  wire                                 cmd_we_i,
    input  wire                                 dvalid_i,      // line data valid
    output logic                                sns_mrst_o,    // low keeps sensor in reset
    output logic [NUM_GP-1:0]                   gp_set_o,      // per-pin mode load
    output sens_io_pkg::gp_mode_e [NUM_GP-1:0]  gp_mode_o,
    output logic                                st_set_o,      // status mode write
    output sens_io_pkg::status_mode_e           st_mode_o,
    output logic [5:0]                          st_seq_o,      // packet sequence number
    output logic                                hact_alive_o   // sticky, dvalid seen
);

    sens_io_pkg::cmd_data_t data_r;       // last write data
    logic                   set_ctrl_r;   // write to SENSIO_CTRL
    logic                   set_status_r; // write to SENSIO_STATUS
    logic                   dvalid_r;     // for edge detect

    always_ff @(posedge pclk) begin
        if (cmd_we_i) begin
            data_r <= cmd_data_i;
        end
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            set_ctrl_r   <= 1'b0;
            set_status_r <= 1'b0;
            sns_mrst_o   <= 1'b0;
            gp_set_o     <= '0;
            st_set_o     <= 1'b0;
            dvalid_r     <= 1'b0;
            hact_alive_o <= 1'b0;
        end else begin
            set_ctrl_r   <= cmd_we_i && (cmd_a_i == sens_io_pkg::SENSIO_CTRL);
            set_status_r <= cmd_we_i && (cmd_a_i == sens_io_pkg::SENSIO_STATUS);
            if (set_ctrl_r && data_r[sens_io_pkg::SENS_CTRL_MRST + 1]) begin
                sns_mrst_o <= data_r[sens_io_pkg::SENS_CTRL_MRST]; // only with enable
            end
            for (int i = 0; i < NUM_GP; i++) begin
                gp_set_o[i] <= set_ctrl_r && data_r[sens_io_pkg::SENS_CTRL_GP_BASE +
                                                    sens_io_pkg::SENS_CTRL_GP_STRIDE * i + 2];
            end
            st_set_o <= set_status_r;
            dvalid_r <= dvalid_i;
            if (set_ctrl_r) begin
                hact_alive_o <= 1'b0;          // any control write clears
            end else if (dvalid_i && !dvalid_r) begin
                hact_alive_o <= 1'b1;          // line start
            end
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge pclk) begin
        if (set_ctrl_r) begin
            for (int i = 0; i < NUM_GP; i++) begin
                gp_mode_o[i] <= sens_io_pkg::gp_mode_e'(
                    data_r[sens_io_pkg::SENS_CTRL_GP_BASE +
                           sens_io_pkg::SENS_CTRL_GP_STRIDE * i +: 2]);
            end
        end
        if (set_status_r) begin
            st_mode_o <= sens_io_pkg::status_mode_e'(data_r[1:0]);
            st_seq_o  <= data_r[7:2];
        end
    end

endmodule

`default_nettype wire

// ==== src/sens_gp_pin.sv ====
// one general-purpose sensor pin: mode register, drive level, output enable, input synchronizer
`timescale 1ns/1ps
`default_nettype none

module sens_gp_pin (
    input  wire                        pclk,
    input  wire                        async_prst_with_sens_mrst,
    input  wire                        gp_set_i,    // load new mode
    input  wire sens_io_pkg::gp_mode_e gp_mode_i,
    input  wire                        ext_sync_i,  // trigger source
    input  wire                        gp_pad_i,    // pad level, async
    output logic                       gp_out_o,
    output logic                       gp_oe_o,
    output logic                       gp_in_o      // synchronized pad
);

    sens_io_pkg::gp_mode_e mode_r;
    logic [1:0]            sync_r;   // two-flop synchronizer

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            mode_r <= sens_io_pkg::GP_FLOAT;  // pin floats after reset
            sync_r <= 2'b00;
        end else begin
            if (gp_set_i) begin
                mode_r <= gp_mode_i;
            end
            sync_r <= {sync_r[0], gp_pad_i};
        end
    end

    assign gp_oe_o  = mode_r != sens_io_pkg::GP_FLOAT;
    assign gp_out_o = (mode_r == sens_io_pkg::GP_HIGH) ||
                      ((mode_r == sens_io_pkg::GP_TRIGGER) && ext_sync_i); // trigger passes through
    assign gp_in_o  = sync_r[1];

endmodule

`default_nettype wire

// ==== src/sens_status_gen.sv ====
// status packet generator: requests the status channel and sends address plus two payload bytes
`timescale 1ns/1ps
`default_nettype none

module sens_status_gen #(
    parameter sens_io_pkg::cmd_byte_t STATUS_REG_ADDR = 8'h21, // first packet byte
    parameter int                     NUM_GP          = 4
) (
    input  wire                            pclk,
    input  wire                            async_prst_with_sens_mrst,
    input  wire                            st_set_i,        // status mode write
    input  wire sens_io_pkg::status_mode_e st_mode_i,
    input  wire [5:0]                      st_seq_i,
    input  wire [NUM_GP-1:0]               gp_in_i,
    input  wire [NUM_GP-1:0]               gp_oe_i,
    input  wire                            hact_alive_i,
    input  wire                            senspgm_i,       // board present
    input  wire                            status_start_i,  // grant for the request
    output sens_io_pkg::cmd_byte_t         status_ad_o,
    output logic                           status_rq_o
);

    sens_io_pkg::status_state_e state_r;
    sens_io_pkg::status_mode_e  mode_r;
    sens_io_pkg::status_word_t  status_w;  // live status
    sens_io_pkg::status_word_t  sent_r;    // snapshot being sent / last sent
    logic [5:0]                 seq_r;
    logic                       pend_r;    // single packet owed
    logic                       due;

    assign status_w = {senspgm_i, hact_alive_i, gp_oe_i, gp_in_i};
    assign due      = pend_r || (mode_r == sens_io_pkg::ST_ALWAYS) ||
                      ((mode_r == sens_io_pkg::ST_AUTO) && (status_w != sent_r)); // on change

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            state_r <= sens_io_pkg::ST_IDLE;
            mode_r  <= sens_io_pkg::ST_OFF;
            pend_r  <= 1'b0;
            sent_r  <= '0;
        end else begin
            if (st_set_i) begin
                mode_r <= st_mode_i;
                pend_r <= st_mode_i == sens_io_pkg::ST_SINGLE; // other modes cancel
            end else if (state_r == sens_io_pkg::ST_IDLE) begin
                pend_r <= 1'b0;                 // taken below if it was set
            end
            case (state_r)
                sens_io_pkg::ST_IDLE: begin
                    if (due) begin
                        state_r <= sens_io_pkg::ST_REQ;
                        sent_r  <= status_w;    // frozen until packet is out
                    end
                end
                sens_io_pkg::ST_REQ: begin
                    if (status_start_i) begin
                        state_r <= sens_io_pkg::ST_B1;
                    end
                end
                sens_io_pkg::ST_B1: state_r <= sens_io_pkg::ST_B2;
                default:            state_r <= sens_io_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (st_set_i) begin
            seq_r <= st_seq_i;
        end
    end

    always_comb begin
        status_rq_o = 1'b0;
        case (state_r)
            sens_io_pkg::ST_REQ: begin
                status_rq_o = 1'b1;
                status_ad_o = STATUS_REG_ADDR;    // held until start
            end
            sens_io_pkg::ST_B1: status_ad_o = {seq_r, sent_r[1:0]};
            sens_io_pkg::ST_B2: status_ad_o = sent_r[9:2];
            default:            status_ad_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/sens_io_top.sv ====
// sensor port control plane top: command decode, control register, GP pins and status sender
`timescale 1ns/1ps
`default_nettype none

module sens_io_top #(
    parameter sens_io_pkg::cmd_full_addr_t SENSIO_ADDR      = 16'h0330,
    parameter sens_io_pkg::cmd_full_addr_t SENSIO_ADDR_MASK = 16'h07f8,
    parameter sens_io_pkg::cmd_byte_t      STATUS_REG_ADDR  = 8'h21,
    parameter int                          NUM_GP           = 4
) (
    input  wire                         pclk,
    input  wire                         async_prst_with_sens_mrst,
    input  wire sens_io_pkg::cmd_byte_t cmd_ad_i,
    input  wire                         cmd_stb_i,
    output sens_io_pkg::cmd_byte_t      status_ad_o,
    output logic                        status_rq_o,
    input  wire                         status_start_i,
    input  wire                         ext_sync_i,    // per-sensor trigger
    input  wire                         dvalid_i,
    input  wire                         senspgm_i,
    output logic                        sns_mrst_o,
    input  wire [NUM_GP-1:0]            gp_pad_i,
    output logic [NUM_GP-1:0]           gp_out_o,
    output logic [NUM_GP-1:0]           gp_oe_o
);

    sens_io_pkg::cmd_addr_t                cmd_a;
    sens_io_pkg::cmd_data_t                cmd_data;
    logic                                  cmd_we;
    logic [NUM_GP-1:0]                     gp_set;
    sens_io_pkg::gp_mode_e [NUM_GP-1:0]    gp_mode;
    logic [NUM_GP-1:0]                     gp_in;
    logic                                  st_set;
    sens_io_pkg::status_mode_e             st_mode;
    logic [5:0]                            st_seq;
    logic                                  hact_alive;

    sens_cmd_deser #(
        .SENSIO_ADDR      (SENSIO_ADDR),
        .SENSIO_ADDR_MASK (SENSIO_ADDR_MASK)
    ) u_cmd_deser (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .cmd_a_o                   (cmd_a),
        .cmd_data_o                (cmd_data),
        .cmd_we_o                  (cmd_we)
    );

    sens_ctrl_regs #(
        .NUM_GP (NUM_GP)
    ) u_ctrl_regs (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_a_i                   (cmd_a),
        .cmd_data_i                (cmd_data),
        .cmd_we_i                  (cmd_we),
        .dvalid_i                  (dvalid_i),
        .sns_mrst_o                (sns_mrst_o),
        .gp_set_o                  (gp_set),
        .gp_mode_o                 (gp_mode),
        .st_set_o                  (st_set),
        .st_mode_o                 (st_mode),
        .st_seq_o                  (st_seq),
        .hact_alive_o              (hact_alive)
    );

    for (genvar i = 0; i < NUM_GP; i++) begin : g_pin
        sens_gp_pin u_gp_pin (
            .pclk                      (pclk),
            .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
            .gp_set_i                  (gp_set[i]),
            .gp_mode_i                 (gp_mode[i]),
            .ext_sync_i                (ext_sync_i),
            .gp_pad_i                  (gp_pad_i[i]),
            .gp_out_o                  (gp_out_o[i]),
            .gp_oe_o                   (gp_oe_o[i]),
            .gp_in_o                   (gp_in[i])
        );
    end

    sens_status_gen #(
        .STATUS_REG_ADDR (STATUS_REG_ADDR),
        .NUM_GP          (NUM_GP)
    ) u_status_gen (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .st_set_i                  (st_set),
        .st_mode_i                 (st_mode),
        .st_seq_i                  (st_seq),
        .gp_in_i                   (gp_in),
        .gp_oe_i                   (gp_oe_o),     // enables go into the status word
        .hact_alive_i              (hact_alive),
        .senspgm_i                 (senspgm_i),
        .status_start_i            (status_start_i),
        .status_ad_o               (status_ad_o),
        .status_rq_o               (status_rq_o)
    );

endmodule

`default_nettype wire

// ==== tests/sens_io_sva.sv ====
// bound port checks for the sensor port: GP enables after a command, status request exchange
`timescale 1ns/1ps
`default_nettype none

module sens_io_sva #(
    parameter int                     NUM_GP          = 4,
    parameter sens_io_pkg::cmd_byte_t STATUS_REG_ADDR = 8'h21
) (
    input wire              pclk,
    input wire              async_prst_with_sens_mrst,
    input wire              cmd_stb_i,
    input wire              status_start_i,
    input wire              status_rq_i,     // top status_rq_o
    input wire [7:0]        status_ad_i,     // top status_ad_o
    input wire [NUM_GP-1:0] gp_oe_i          // top gp_oe_o
);

    int   fail_cnt = 0;  // summed into the closing line
    logic cmd_seen_r;    // any command strobe since reset

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            cmd_seen_r <= 1'b0;
        end else if (cmd_stb_i) begin
            cmd_seen_r <= 1'b1;
        end
    end

    oe_after_cmd: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        (gp_oe_i != '0) |-> cmd_seen_r) else begin
        fail_cnt++;
        $error("gp_oe_o went high with no command written");
    end

    rq_drops: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        (status_rq_i && status_start_i) |=> !status_rq_i) else begin
        fail_cnt++;
        $error("status_rq_o still high the cycle after status_start_i");
    end

    rq_holds: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        (status_rq_i && !status_start_i) |=> (status_rq_i && status_ad_i == STATUS_REG_ADDR))
        else begin
        fail_cnt++;
        $error("status request dropped or address byte lost before start");
    end

endmodule

bind sens_io_top sens_io_sva #(.NUM_GP(NUM_GP), .STATUS_REG_ADDR(STATUS_REG_ADDR)) u_sva (
    .pclk                      (pclk),
    .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
    .cmd_stb_i                 (cmd_stb_i),
    .status_start_i            (status_start_i),
    .status_rq_i               (status_rq_o),
    .status_ad_i               (status_ad_o),
    .gp_oe_i                   (gp_oe_o)
);

`default_nettype wire

// ==== tests/tb_sens_io.sv ====
// testbench for the sensor port control plane with command, GP pin and status packet checks
`timescale 1ns/1ps
`default_nettype none

module tb_sens_io;

    localparam int          NUM_GP    = 4;
    localparam logic [7:0]  ST_ADDR   = 8'h21;    // first status byte
    localparam logic [15:0] ADDR_CTRL = 16'h0330;
    localparam logic [15:0] ADDR_STAT = 16'h0331;
    localparam int          NUM_CMDS  = 15;       // commands sent over the whole run
    localparam int          RQ_WAIT   = 64;       // cycles allowed for a request

    logic              pclk;
    logic              async_prst_with_sens_mrst;
    logic [7:0]        cmd_ad_i;
    logic              cmd_stb_i;
    logic              status_start_i;
    logic              ext_sync_i;
    logic              dvalid_i;
    logic              senspgm_i;
    logic [NUM_GP-1:0] gp_pad_i;
    logic [7:0]        status_ad_o;
    logic              status_rq_o;
    logic              sns_mrst_o;
    logic [NUM_GP-1:0] gp_out_o;
    logic [NUM_GP-1:0] gp_oe_o;
    logic [1:0]        mode_exp [NUM_GP];         // 0 float, 1 low, 2 high, 3 trigger
    logic              mrst_exp;
    logic              hact_exp;                  // line-active flag model
    logic [5:0]        seq;
    integer            seed = 77;
    int                checks = 0;
    int                errors = 0;

    sens_io_top #(
        .SENSIO_ADDR      (16'h0330),
        .SENSIO_ADDR_MASK (16'h07f8),
        .STATUS_REG_ADDR  (ST_ADDR),
        .NUM_GP           (NUM_GP)
    ) UUT (.*);

    initial begin
        pclk = 1'b0;
        forever #20 pclk = ~pclk;
    end

    initial begin                                 // watchdog
        #((NUM_CMDS * 12 + 2000) * 40);
        $display("timeout: run did not end within %0d cycles", NUM_CMDS * 12 + 2000);
        $display("Something failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name, expected,
                     actual);
        end
    endtask

    function automatic logic [31:0] ctrl_word(input logic mrst_en, input logic mrst_val,
                                              input logic [7:0] modes, input logic [3:0] en);
        logic [31:0] w;
        w    = '0;
        w[0] = mrst_val;
        w[1] = mrst_en;
        for (int i = 0; i < NUM_GP; i++) begin
            w[12 + 3 * i +: 2] = modes[2 * i +: 2];  // mode field
            w[14 + 3 * i]      = en[i];              // its enable
        end
        return w;
    endfunction

    function automatic logic [9:0] status_exp();
        logic [NUM_GP-1:0] oe;
        for (int i = 0; i < NUM_GP; i++) begin
            oe[i] = mode_exp[i] != 2'd0;
        end
        return {senspgm_i, hact_exp, oe, gp_pad_i};  // pad levels as seen after the sync
    endfunction

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] frame;
        frame = {data, addr};                     // AL first and D3 last
        @(posedge pclk);
        cmd_stb_i <= 1'b1;
        cmd_ad_i  <= frame[7:0];
        for (int b = 1; b < 6; b++) begin
            @(posedge pclk);
            cmd_stb_i <= 1'b0;
            cmd_ad_i  <= frame[8 * b +: 8];
        end
        @(posedge pclk);
        cmd_ad_i <= 8'h00;
    endtask

    task automatic check_pins();
        for (int i = 0; i < NUM_GP; i++) begin
            check_val($sformatf("gp_oe_o[%0d]", i), gp_oe_o[i], mode_exp[i] != 2'd0);
            check_val($sformatf("gp_out_o[%0d]", i), gp_out_o[i],
                      mode_exp[i] == 2'd2 || (mode_exp[i] == 2'd3 && ext_sync_i));
        end
        check_val("sns_mrst_o", sns_mrst_o, mrst_exp);
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge pclk);
            check_pins();
            check_val("status_rq_o", status_rq_o, 1'b0);
        end
    endtask

    task automatic write_ctrl(input logic mrst_en, input logic mrst_val,
                              input logic [7:0] modes, input logic [3:0] en);
        send_cmd(ADDR_CTRL, ctrl_word(mrst_en, mrst_val, modes, en));
        @(negedge pclk);                          // cmd_we high
        @(negedge pclk);                          // regs loaded and reset not moved yet
        check_val("sns_mrst_o", sns_mrst_o, mrst_exp);
        if (mrst_en) begin
            mrst_exp = mrst_val;
        end
        @(negedge pclk);
        check_val("sns_mrst_o", sns_mrst_o, mrst_exp);
        for (int i = 0; i < NUM_GP; i++) begin
            if (en[i]) begin
                mode_exp[i] = modes[2 * i +: 2];
            end
        end
        @(negedge pclk);                          // pin modes one cycle later
        check_pins();
        hact_exp = 1'b0;                          // any control write clears it
    endtask

    task automatic recv_packet(input logic [5:0] seq_e, input logic [9:0] word);
        int waited;
        int delay;
        waited = 0;
        do begin
            @(negedge pclk);
            waited++;
        end while (!status_rq_o && waited < RQ_WAIT);
        checks++;
        assert (status_rq_o) else begin
            errors++;
            $display("no status request within %0d cycles at %0t ns", RQ_WAIT, $time);
        end
        if (status_rq_o) begin
            delay = 1 + (($random(seed) & 32'h7fff_ffff) % 6);  // late grant
            repeat (delay) begin
                check_val("status_rq_o", status_rq_o, 1'b1);
                check_val("status_ad_o", status_ad_o, ST_ADDR);
                @(negedge pclk);
            end
            @(posedge pclk);
            status_start_i <= 1'b1;
            @(posedge pclk);
            status_start_i <= 1'b0;
            @(negedge pclk);
            check_val("status_rq_o", status_rq_o, 1'b0);
            check_val("status_ad_o byte 1", status_ad_o, {seq_e, word[1:0]});
            @(negedge pclk);
            check_val("status_ad_o byte 2", status_ad_o, word[9:2]);
        end
    endtask

    initial begin
        async_prst_with_sens_mrst = 1'b1;
        cmd_ad_i       = 8'h00;
        cmd_stb_i      = 1'b0;
        status_start_i = 1'b0;
        ext_sync_i     = 1'b0;
        dvalid_i       = 1'b0;
        senspgm_i      = 1'b1;                    // board present
        gp_pad_i       = '0;
        mrst_exp       = 1'b0;
        hact_exp       = 1'b0;
        for (int i = 0; i < NUM_GP; i++) begin
            mode_exp[i] = 2'd0;
        end
        repeat (10) @(posedge pclk);
        async_prst_with_sens_mrst <= 1'b0;
        check_quiet(2);

        write_ctrl(1'b1, 1'b1, 8'h00, 4'h0);      // sensor reset follows its enable
        write_ctrl(1'b0, 1'b0, 8'h00, 4'h0);
        write_ctrl(1'b1, 1'b0, 8'h00, 4'h0);
        write_ctrl(1'b1, 1'b1, 8'h00, 4'h0);

        for (int r = 0; r < 6; r++) begin         // all four modes and then random ones
            if (r == 0) begin
                write_ctrl(1'b0, 1'b0, 8'b00_01_10_11, 4'hf);
            end else begin
                write_ctrl(1'b0, 1'b0, 8'($random(seed)), 4'($random(seed)));
            end
            repeat (4) begin
                @(posedge pclk);
                ext_sync_i <= ~ext_sync_i;
                @(negedge pclk);
                check_pins();
            end
        end

        send_cmd(16'h0730, ctrl_word(1'b1, 1'b0, 8'hff, 4'hf));  // address bit 10 off
        send_cmd(16'h0339, 32'h0000_0003);       // bit 3 off so no ST_ALWAYS
        check_quiet(12);

        @(posedge pclk);
        gp_pad_i <= 4'($random(seed));
        seq = 6'($random(seed));
        send_cmd(ADDR_STAT, {24'h0, seq, 2'd1}); // ST_SINGLE
        @(negedge pclk);
        recv_packet(seq, status_exp());
        check_quiet(12);

        seq = 6'($random(seed));
        send_cmd(ADDR_STAT, {24'h0, seq, 2'd2}); // ST_AUTO with status unchanged
        check_quiet(12);
        @(posedge pclk);
        dvalid_i <= 1'b1;
        @(posedge pclk);
        dvalid_i <= 1'b0;
        hact_exp = 1'b1;
        @(negedge pclk);
        recv_packet(seq, status_exp());
        @(posedge pclk);
        gp_pad_i <= gp_pad_i ^ (4'($random(seed)) | 4'h1);
        @(negedge pclk);
        recv_packet(seq, status_exp());
        @(posedge pclk);
        senspgm_i <= 1'b0;                        // board removed
        @(negedge pclk);
        recv_packet(seq, status_exp());
        write_ctrl(1'b0, 1'b0, 8'h00, 4'h0);      // flag cleared so new packet
        recv_packet(seq, status_exp());
        check_quiet(12);

        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 UUT.u_sva.fail_cnt);
        if (errors == 0 && UUT.u_sva.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/sens_io_pkg.sv
src/sens_cmd_deser.sv
src/sens_ctrl_regs.sv
src/sens_gp_pin.sv
src/sens_status_gen.sv
src/sens_io_top.sv
tests/sens_io_sva.sv
tests/tb_sens_io.sv

// ==== Bender.yml ====
package:
  name: sens_io

sources:
  - files:
      - src/sens_io_pkg.sv
      - src/sens_cmd_deser.sv
      - src/sens_ctrl_regs.sv
      - src/sens_gp_pin.sv
      - src/sens_status_gen.sv
      - src/sens_io_top.sv
  - target: test
    files:
      - tests/sens_io_sva.sv
      - tests/tb_sens_io.sv
